//--- dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address and data widths
`define DC_ADDR_W     32
`define DC_WORD_W     32

// Cache geometry
`define DC_LINE_WORDS 4
`define DC_NSET       16
`define DC_NWAY       2

// Address split into tag, index and byte offset
`define DC_OFFSET_W   4
`define DC_INDEX_W    4
`define DC_TAG_W      24

// Victim LFSR start value, never zero
`define DC_LFSR_SEED  16'hace1

`endif

//--- dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]                   addr_t;
    typedef logic [`DC_WORD_W-1:0]                   word_t;
    typedef logic [`DC_WORD_W/8-1:0]                 strb_t;
    typedef logic [`DC_TAG_W-1:0]                    tag_t;
    typedef logic [`DC_INDEX_W-1:0]                  index_t;
    typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0]    line_t;
    typedef logic [`DC_LINE_WORDS*`DC_WORD_W/8-1:0]  line_be_t;
    typedef logic [$clog2(`DC_NWAY)-1:0]             way_sel_t;

    // Core request, a store has nonzero strb
    typedef struct packed {
        addr_t addr;
        strb_t strb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_entry_t;

    // One way's write port
    typedef struct packed {
        logic       en;
        index_t     index;
        way_entry_t entry;
        line_be_t   be;
    } way_wr_t;

    // Wishbone master outputs
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
        strb_t sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        WB_BEAT,
        REFILL_BEAT,
        FILL_WRITE
    } miss_state_e;

endpackage

//--- cache_way_ram.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module cache_way_ram
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_en_i,
    input  index_t     rd_index_i,
    output way_entry_t rd_o,
    input  way_wr_t    wr_i
);

    logic [`DC_NSET-1:0] valid_q;
    logic [`DC_NSET-1:0] dirty_q;
    tag_t                tag_q  [`DC_NSET];
    line_t               line_q [`DC_NSET];

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.index] <= wr_i.entry.valid;
        end
    end

    // Dirty, tag and byte-enabled line data
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            dirty_q[wr_i.index] <= wr_i.entry.dirty;
            tag_q[wr_i.index]   <= wr_i.entry.tag;
            for (int b = 0; b < $bits(line_be_t); b++) begin
                if (wr_i.be[b]) begin
                    line_q[wr_i.index][b*8 +: 8] <= wr_i.entry.line[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, holds until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_o.valid <= valid_q[rd_index_i];
            rd_o.dirty <= dirty_q[rd_index_i];
            rd_o.tag   <= tag_q[rd_index_i];
            rd_o.line  <= line_q[rd_index_i];
        end
    end

    // Every write from lookup or refill touches at least one byte
    assert property (@(posedge clk) disable iff (rst) wr_i.en |-> wr_i.be != '0);

endmodule

//--- dcache_lookup.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_valid_i,
    input  cpu_req_t   cpu_req_i,
    output logic       cpu_ready_o,
    output logic       data_ok_o,
    output word_t      rdata_o,
    output logic       rd_en_o,
    output index_t     rd_index_o,
    input  way_entry_t way_rd_i [`DC_NWAY],
    output way_wr_t    way_wr_o [`DC_NWAY],
    output logic       miss_o,
    output cpu_req_t   miss_req_o,
    input  way_wr_t    fill_wr_i,
    input  way_sel_t   fill_way_i,
    input  logic       fill_done_i,
    input  line_t      fill_line_i
);

    logic                    accept;
    logic                    slot_valid_q;
    cpu_req_t                slot_req_q;
    tag_t                    slot_tag;
    index_t                  slot_index;
    logic [`DC_OFFSET_W-3:0] slot_word;
    logic                    slot_store;
    logic [`DC_NWAY-1:0]     way_hit;
    logic                    hit_any;
    line_t                   hit_line;

    ////////////////////////////////////////////////////////////
    // Lookup: accept and start the RAM read
    ////////////////////////////////////////////////////////////
    assign accept     = cpu_valid_i & cpu_ready_o;
    assign rd_en_o    = accept;
    assign rd_index_o = cpu_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid_q <= 1'b0;
        end else if (accept) begin
            slot_valid_q <= 1'b1;
        end else if (data_ok_o) begin
            slot_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_req_q <= cpu_req_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Resolve: tag compare and answer
    ////////////////////////////////////////////////////////////
    assign slot_tag   = slot_req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign slot_index = slot_req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign slot_word  = slot_req_q.addr[`DC_OFFSET_W-1:2];
    assign slot_store = |slot_req_q.strb;

    always_comb begin
        way_hit  = '0;
        hit_line = way_rd_i[0].line;
        for (int w = 0; w < `DC_NWAY; w++) begin
            way_hit[w] = way_rd_i[w].valid && (way_rd_i[w].tag == slot_tag);
            if (way_hit[w]) begin
                hit_line = way_rd_i[w].line;
            end
        end
    end

    assign hit_any    = slot_valid_q & (|way_hit);
    assign miss_o     = slot_valid_q & ~(|way_hit);
    assign miss_req_o = slot_req_q;

    // Miss answers in the cycle of the fill write
    assign data_ok_o = hit_any | (miss_o & fill_done_i);
    assign rdata_o   = hit_any ? hit_line[slot_word*`DC_WORD_W +: `DC_WORD_W]
                               : fill_line_i[slot_word*`DC_WORD_W +: `DC_WORD_W];

    // Store hit or miss blocks the next request
    assign cpu_ready_o = ~slot_valid_q | (hit_any & ~slot_store);

    // RAM write ports: refill during a miss, else store hit
    always_comb begin
        for (int w = 0; w < `DC_NWAY; w++) begin
            way_wr_o[w] = '0;
            if (miss_o) begin
                if (fill_way_i == way_sel_t'(w)) begin
                    way_wr_o[w] = fill_wr_i;
                end
            end else if (slot_valid_q && slot_store && way_hit[w]) begin
                way_wr_o[w].en          = 1'b1;
                way_wr_o[w].index       = slot_index;
                way_wr_o[w].entry.valid = 1'b1;
                way_wr_o[w].entry.dirty = 1'b1;
                way_wr_o[w].entry.tag   = slot_tag;
                way_wr_o[w].entry.line  = {`DC_LINE_WORDS{slot_req_q.wdata}};
                way_wr_o[w].be          = line_be_t'(slot_req_q.strb) << {slot_word, 2'b00};
            end
        end
    end

    // Refill ends only a pending miss
    assert property (@(posedge clk) disable iff (rst) fill_done_i |-> miss_o);

endmodule

//--- dcache_miss_ctrl.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       miss_i,
    input  cpu_req_t   miss_req_i,
    input  way_entry_t way_rd_i [`DC_NWAY],
    output wb_req_t    wb_req_o,
    input  wb_rsp_t    wb_rsp_i,
    output way_wr_t    fill_wr_o,
    output way_sel_t   fill_way_o,
    output logic       fill_done_o,
    output line_t      fill_line_o
);

    logic [15:0]             lfsr_q;
    way_sel_t                lfsr_way;
    miss_state_e             state_q;
    cpu_req_t                req_q;
    way_sel_t                victim_q;
    logic [`DC_OFFSET_W-3:0] beat_q;
    logic                    last_beat;
    line_t                   line_q;
    way_entry_t              pick;
    way_entry_t              victim;
    tag_t                    req_tag;
    index_t                  req_index;
    logic [`DC_OFFSET_W-3:0] req_word;
    line_t                   merged_line;

    // Fibonacci LFSR, taps 16 14 13 11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= `DC_LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    assign lfsr_way = lfsr_q[$bits(way_sel_t)-1:0];
    assign pick     = way_rd_i[lfsr_way];

    // RAM output holds through the miss, so the victim entry stays readable
    assign victim    = way_rd_i[victim_q];
    assign req_tag   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_word  = req_q.addr[`DC_OFFSET_W-1:2];
    assign last_beat = beat_q == (`DC_OFFSET_W-2)'(`DC_LINE_WORDS - 1);

    ////////////////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss_i) begin
                        beat_q <= '0;
                        if (pick.valid && pick.dirty) begin
                            state_q <= WB_BEAT;
                        end else begin
                            state_q <= REFILL_BEAT;
                        end
                    end
                end
                WB_BEAT: begin
                    if (wb_rsp_i.ack) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= REFILL_BEAT;
                        end
                    end
                end
                REFILL_BEAT: begin
                    if (wb_rsp_i.ack) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= FILL_WRITE;
                        end
                    end
                end
                FILL_WRITE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request, victim and refill buffer
    always_ff @(posedge clk) begin
        if (state_q == IDLE && miss_i) begin
            req_q    <= miss_req_i;
            victim_q <= lfsr_way;
        end
        if (state_q == REFILL_BEAT && wb_rsp_i.ack) begin
            line_q[beat_q*`DC_WORD_W +: `DC_WORD_W] <= wb_rsp_i.dat;
        end
    end

    ////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////
    always_comb begin
        wb_req_o = '0;
        case (state_q)
            WB_BEAT: begin
                wb_req_o.cyc = 1'b1;
                wb_req_o.stb = 1'b1;
                wb_req_o.we  = 1'b1;
                wb_req_o.adr = {victim.tag, req_index, beat_q, 2'b00};
                wb_req_o.dat = victim.line[beat_q*`DC_WORD_W +: `DC_WORD_W];
                wb_req_o.sel = '1;
            end
            REFILL_BEAT: begin
                wb_req_o.cyc = 1'b1;
                wb_req_o.stb = 1'b1;
                wb_req_o.adr = {req_tag, req_index, beat_q, 2'b00};
                wb_req_o.sel = '1;
            end
            default: begin
            end
        endcase
    end

    // Pending store bytes over the refilled word
    always_comb begin
        merged_line = line_q;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (req_q.strb[b]) begin
                merged_line[req_word*`DC_WORD_W + b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        fill_wr_o = '0;
        if (state_q == FILL_WRITE) begin
            fill_wr_o.en          = 1'b1;
            fill_wr_o.index       = req_index;
            fill_wr_o.entry.valid = 1'b1;
            fill_wr_o.entry.dirty = |req_q.strb;
            fill_wr_o.entry.tag   = req_tag;
            fill_wr_o.entry.line  = merged_line;
            fill_wr_o.be          = '1;
        end
    end

    assign fill_way_o  = victim_q;
    assign fill_done_o = state_q == FILL_WRITE;
    assign fill_line_o = merged_line;

    // Bus request held steady until the slave acks
    assert property (@(posedge clk) disable iff (rst)
        wb_req_o.stb && !wb_rsp_i.ack |=> $stable(wb_req_o));

endmodule

//--- dcache_top.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cpu_valid_i,
    input  cpu_req_t cpu_req_i,
    output logic     cpu_ready_o,
    output logic     data_ok_o,
    output word_t    rdata_o,
    output wb_req_t  wb_req_o,
    input  wb_rsp_t  wb_rsp_i
);

    logic       rd_en;
    index_t     rd_index;
    way_entry_t way_rd [`DC_NWAY];
    way_wr_t    way_wr [`DC_NWAY];
    logic       miss;
    cpu_req_t   miss_req;
    way_wr_t    fill_wr;
    way_sel_t   fill_way;
    logic       fill_done;
    line_t      fill_line;

    // One RAM per way, shared read index
    generate
        for (genvar g = 0; g < `DC_NWAY; g++) begin : g_way
            cache_way_ram u_way_ram (
                .clk        (clk),
                .rst        (rst),
                .rd_en_i    (rd_en),
                .rd_index_i (rd_index),
                .rd_o       (way_rd[g]),
                .wr_i       (way_wr[g])
            );
        end
    endgenerate

    dcache_lookup u_lookup (
        .clk         (clk),
        .rst         (rst),
        .cpu_valid_i (cpu_valid_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_ready_o (cpu_ready_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .rd_en_o     (rd_en),
        .rd_index_o  (rd_index),
        .way_rd_i    (way_rd),
        .way_wr_o    (way_wr),
        .miss_o      (miss),
        .miss_req_o  (miss_req),
        .fill_wr_i   (fill_wr),
        .fill_way_i  (fill_way),
        .fill_done_i (fill_done),
        .fill_line_i (fill_line)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk         (clk),
        .rst         (rst),
        .miss_i      (miss),
        .miss_req_i  (miss_req),
        .way_rd_i    (way_rd),
        .wb_req_o    (wb_req_o),
        .wb_rsp_i    (wb_rsp_i),
        .fill_wr_o   (fill_wr),
        .fill_way_o  (fill_way),
        .fill_done_o (fill_done),
        .fill_line_o (fill_line)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // Reset held over the first four rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- tb_wb_mem.sv
`timescale 1ns/10ps

module tb_wb_mem
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    word_t      mem [addr_t];
    integer     seed = 32'h2d70;
    logic       busy_q;
    logic [1:0] wait_q;

    // Untouched words read as word address XOR 5a5a_0000
    function automatic word_t read_word(input addr_t wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end else begin
            return wa ^ 32'h5a5a_0000;
        end
    endfunction

    initial begin
        wb_rsp_o = '0;
        busy_q   = 1'b0;
        wait_q   = '0;
    end

    ////////////////////////////////////////////////////////////
    // Classic slave, 0 to 3 wait cycles per beat
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        int    draw;
        logic  fire;
        addr_t wa;
        word_t word;
        fire = 1'b0;
        wa   = wb_req_i.adr >> 2;
        if (rst) begin
            wb_rsp_o <= '0;
            busy_q   <= 1'b0;
            wait_q   <= '0;
        end else begin
            wb_rsp_o.ack <= 1'b0;
            // Skip the cycle where the previous ack is still visible
            if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack) begin
                if (!busy_q) begin
                    draw = $random(seed) & 32'h3;
                    if (draw == 0) begin
                        fire = 1'b1;
                    end else begin
                        busy_q <= 1'b1;
                        wait_q <= 2'(draw - 1);
                    end
                end else if (wait_q == 0) begin
                    busy_q <= 1'b0;
                    fire   = 1'b1;
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
            if (fire) begin
                wb_rsp_o.ack <= 1'b1;
                word = read_word(wa);
                if (wb_req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req_i.sel[b]) begin
                            word[b*8 +: 8] = wb_req_i.dat[b*8 +: 8];
                        end
                    end
                    mem[wa] = word;
                end else begin
                    wb_rsp_o.dat <= word;
                end
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam logic [1:0] K_ANY  = 2'd0;
    localparam logic [1:0] K_HIT  = 2'd1;
    localparam logic [1:0] K_MISS = 2'd2;
    localparam int         TIMEOUT = 500;

    // One accepted request with what the core expects back
    typedef struct packed {
        cpu_req_t    req;
        logic [1:0]  kind;
        word_t       exp;
        logic [31:0] cycle;
    } pend_t;

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    cpu_req_t    cpu_req;
    logic        cpu_ready;
    logic        data_ok;
    word_t       rdata;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    pend_t       pend_q [$];
    pend_t       head;
    logic        head_valid;
    word_t       shadow [addr_t];
    logic [1:0]  cur_kind;
    logic [31:0] cycle_q;
    int          rd_beats;
    int          wr_beats;
    word_t       wb_exp;
    integer      seed = 32'h2d70;

    tb_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    dcache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .cpu_valid_i (cpu_valid),
        .cpu_req_i   (cpu_req),
        .cpu_ready_o (cpu_ready),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata),
        .wb_req_o    (wb_req),
        .wb_rsp_i    (wb_rsp)
    );

    tb_wb_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on first error");
    endtask

    function automatic word_t shadow_read(input addr_t addr);
        addr_t wa;
        wa = addr >> 2;
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end else begin
            return wa ^ 32'h5a5a_0000;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Scoreboard: shadow memory and request queue
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        pend_t ent;
        word_t w;
        if (rst) begin
            pend_q.delete();
            cycle_q  = '0;
            rd_beats = 0;
            wr_beats = 0;
        end else begin
            if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
                if (wb_req.we) begin
                    wr_beats++;
                end else begin
                    rd_beats++;
                end
            end
            if (data_ok && pend_q.size() != 0) begin
                void'(pend_q.pop_front());
            end
            if (cpu_valid && cpu_ready) begin
                ent.req   = cpu_req;
                ent.kind  = cur_kind;
                ent.exp   = shadow_read(cpu_req.addr);
                ent.cycle = cycle_q;
                pend_q.push_back(ent);
                w = ent.exp;
                for (int b = 0; b < 4; b++) begin
                    if (cpu_req.strb[b]) begin
                        w[b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
                    end
                end
                shadow[cpu_req.addr >> 2] = w;
                rd_beats = 0;
            end
            cycle_q = cycle_q + 1;
        end
        head_valid = pend_q.size() != 0;
        head       = head_valid ? pend_q[0] : '0;
    end

    // Bus outputs are settled by the falling edge
    always @(negedge clk) begin
        wb_exp = shadow_read(wb_req.adr);
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
            cpu_ready && !data_ok && !wb_req.cyc && !wb_req.stb)
        else begin
            $display("error: %0t ns: ready, data_ok or bus strobes wrong after reset", $time);
            fail_run();
        end

    a_ok_has_req: assert property (@(posedge clk) disable iff (rst) data_ok |-> head_valid)
        else begin
            $display("data_ok_o was raised with no request waiting for an answer");
            fail_run();
        end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
            data_ok && head_valid && head.req.strb == '0 |-> rdata == head.exp)
        else begin
            $display("error: %0t ns: load at %h returned %h, expected %h", $time,
                     $sampled(head.req.addr), $sampled(rdata), $sampled(head.exp));
            fail_run();
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
            data_ok && head.kind == K_HIT |-> cycle_q == head.cycle + 1)
        else begin
            $display("error: %0t ns: hit at %h not answered one edge after acceptance",
                     $time, $sampled(head.req.addr));
            fail_run();
        end

    a_hit_no_bus: assert property (@(posedge clk) disable iff (rst)
            data_ok && head.kind == K_HIT |-> !wb_req.cyc)
        else begin
            $display("error: %0t ns: bus cycle seen during a hit", $time);
            fail_run();
        end

    a_load_hit_ready: assert property (@(posedge clk) disable iff (rst)
            data_ok && head.kind == K_HIT && head.req.strb == '0 |-> cpu_ready)
        else begin
            $display("error: %0t ns: cpu_ready_o dropped after a load hit", $time);
            fail_run();
        end

    a_store_hit_stall: assert property (@(posedge clk) disable iff (rst)
            data_ok && head.kind == K_HIT && head.req.strb != '0 |-> !cpu_ready)
        else begin
            $display("error: %0t ns: cpu_ready_o high in a store hit cycle", $time);
            fail_run();
        end

    a_miss_refill: assert property (@(posedge clk) disable iff (rst)
            data_ok && head.kind == K_MISS |-> rd_beats == 4)
        else begin
            $display("error: %0t ns: miss at %h answered after %0d read beats", $time,
                     $sampled(head.req.addr), $sampled(rd_beats));
            fail_run();
        end

    a_miss_stall: assert property (@(posedge clk) disable iff (rst) wb_req.cyc |-> !cpu_ready)
        else begin
            $display("error: %0t ns: cpu_ready_o high during a bus cycle", $time);
            fail_run();
        end

    a_wb_full_word: assert property (@(posedge clk) disable iff (rst)
            wb_req.cyc && wb_req.stb |-> wb_req.sel == 4'hf)
        else begin
            $display("error: %0t ns: bus beat at %h has byte selects %b, expected 1111", $time,
                     $sampled(wb_req.adr), $sampled(wb_req.sel));
            fail_run();
        end

    a_wb_write_data: assert property (@(posedge clk) disable iff (rst)
            wb_req.cyc && wb_req.stb && wb_req.we |-> wb_req.dat == wb_exp)
        else begin
            $display("error: %0t ns: write-back to %h carries %h, expected %h", $time,
                     $sampled(wb_req.adr), $sampled(wb_req.dat), $sampled(wb_exp));
            fail_run();
        end

    ////////////////////////////////////////////////////////////
    // Stimulus, called on a falling edge
    ////////////////////////////////////////////////////////////
    task automatic send(input addr_t addr, input strb_t strb, input word_t wdata,
                        input logic [1:0] kind);
        int waited;
        waited    = 0;
        cpu_req   = '{addr: addr, strb: strb, wdata: wdata};
        cpu_valid = 1'b1;
        cur_kind  = kind;
        while (!cpu_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: request to %h was never accepted", addr);
                fail_run();
            end
        end
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic load(input addr_t addr, input logic [1:0] kind);
        send(addr, '0, '0, kind);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (head_valid) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: the cache never answered all pending requests");
                fail_run();
            end
        end
    endtask

    initial begin
        int    waited;
        int    pick;
        addr_t lines [3];
        addr_t off;
        strb_t strb_set [5];
        $timeformat(-9, 0, "", 0);
        cpu_valid   = 1'b0;
        cpu_req     = '0;
        cur_kind    = K_ANY;
        lines       = '{32'h0000_4020, 32'h0000_4120, 32'h0000_4220};
        strb_set    = '{4'b0001, 4'b0010, 4'b1100, 4'b1111, 4'b0110};
        waited      = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: reset was never released");
                fail_run();
            end
        end
        @(negedge clk);

        // Cold miss, then hits in the same line
        load(32'h0000_1040, K_MISS);
        wait_idle();
        load(32'h0000_1044, K_HIT);
        load(32'h0000_1048, K_HIT);
        load(32'h0000_104c, K_HIT);
        load(32'h0000_1040, K_HIT);
        wait_idle();

        // Byte, halfword and word store hits
        send(32'h0000_1041, 4'b0010, 32'h0000_ab00, K_HIT);
        send(32'h0000_1046, 4'b1100, 32'hbeef_0000, K_HIT);
        send(32'h0000_1048, 4'b1111, 32'h1234_5678, K_HIT);
        load(32'h0000_1040, K_HIT);
        load(32'h0000_1044, K_HIT);
        load(32'h0000_1048, K_HIT);
        wait_idle();

        // Stores that miss merge into the refilled line
        send(32'h0000_2050, 4'b0001, 32'h0000_00c3, K_MISS);
        send(32'h0000_3064, 4'b0011, 32'h0000_9a7e, K_MISS);
        load(32'h0000_2050, K_HIT);
        load(32'h0000_2054, K_HIT);
        load(32'h0000_3064, K_HIT);
        wait_idle();

        // Three lines on index 2 in two ways
        for (int l = 0; l < 3; l++) begin
            send(lines[l] + 4, 4'b1111, $random(seed), K_MISS);
        end
        for (int l = 0; l < 3; l++) begin
            load(lines[l] + 4, K_ANY);
        end
        for (int r = 0; r < 4; r++) begin
            for (int l = 0; l < 3; l++) begin
                off  = ($random(seed) & 32'h3) << 2;
                pick = $unsigned($random(seed)) % 5;
                send(lines[l] + off, strb_set[pick], $random(seed), K_ANY);
            end
            for (int l = 0; l < 3; l++) begin
                off = ($random(seed) & 32'h3) << 2;
                load(lines[l] + off, K_ANY);
            end
        end
        wait_idle();

        if (wr_beats < 4) begin
            $display("no dirty line write-back was seen on the Wishbone bus");
            fail_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+.
dcache_pkg.sv
cache_way_ram.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_clkgen.sv
tb_wb_mem.sv
tb_dcache.sv
